/* Makefile */
RTL := src/valu_pkg.sv src/valu_adder.sv src/valu_shifter.sv src/valu_minmax.sv \
       src/valu_result_reg.sv src/valu_top.sv

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --top-module valu_top $(RTL)

obj_dir/Vvalu_tb: files.f $(RTL) tb/valu_tb.sv
	verilator --binary --timing --top-module valu_tb -f files.f

sim: obj_dir/Vvalu_tb
	./obj_dir/Vvalu_tb > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Errors found" sim.log; then \
		echo "Simulation FAILED"; exit 1; \
	elif ! grep -q "No errors" sim.log; then \
		echo "Simulation did not complete"; exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf obj_dir sim.log

/* files.f */
src/valu_pkg.sv
src/valu_adder.sv
src/valu_shifter.sv
src/valu_minmax.sv
src/valu_result_reg.sv
src/valu_top.sv
tb/valu_tb.sv

/* src/valu_adder.sv */
`timescale 1ns/1ps
`default_nettype none

module valu_adder (
    input  valu_pkg::valu_req_t req_i,
    output valu_pkg::vec_t      sum_o
);

    valu_pkg::vec_t minuend;
    valu_pkg::vec_t subtrahend;
    valu_pkg::vec_t subtrahend_neg;
    valu_pkg::vec_t addend;
    logic           is_sub;

    ////////////////////////////////////////
    // Operand steering
    ////////////////////////////////////////

    assign is_sub = (req_i.op == valu_pkg::vsub) || (req_i.op == valu_pkg::vrsub);

    // Reverse subtract swaps the two sources
    always_comb begin
        if (req_i.op == valu_pkg::vrsub) begin
            minuend    = req_i.second_operand;
            subtrahend = req_i.first_operand;
        end else begin
            minuend    = req_i.first_operand;
            subtrahend = req_i.second_operand;
        end
    end

    // Two's-complement negation per element
    always_comb begin
        subtrahend_neg = '0;
        case (req_i.sew)
            valu_pkg::EW8: begin
                for (int i = 0; i < valu_pkg::VLENB; i++) begin
                    subtrahend_neg[8*i +: 8] = ~subtrahend[8*i +: 8] + 8'd1;
                end
            end
            valu_pkg::EW16: begin
                for (int i = 0; i < valu_pkg::VLENB/2; i++) begin
                    subtrahend_neg[16*i +: 16] = ~subtrahend[16*i +: 16] + 16'd1;
                end
            end
            default: begin
                for (int i = 0; i < valu_pkg::VLENB/4; i++) begin
                    subtrahend_neg[32*i +: 32] = ~subtrahend[32*i +: 32] + 32'd1;
                end
            end
        endcase
    end

    assign addend = is_sub ? subtrahend_neg : subtrahend;

    ////////////////////////////////////////
    // Element adders
    ////////////////////////////////////////

    // Carries never leave an element, so each slice wraps on its own
    always_comb begin
        sum_o = '0;
        case (req_i.sew)
            valu_pkg::EW8: begin
                for (int i = 0; i < valu_pkg::VLENB; i++) begin
                    sum_o[8*i +: 8] = minuend[8*i +: 8] + addend[8*i +: 8];
                end
            end
            valu_pkg::EW16: begin
                for (int i = 0; i < valu_pkg::VLENB/2; i++) begin
                    sum_o[16*i +: 16] = minuend[16*i +: 16] + addend[16*i +: 16];
                end
            end
            default: begin
                for (int i = 0; i < valu_pkg::VLENB/4; i++) begin
                    sum_o[32*i +: 32] = minuend[32*i +: 32] + addend[32*i +: 32];
                end
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/valu_minmax.sv */
`timescale 1ns/1ps
`default_nettype none

module valu_minmax (
    input  valu_pkg::valu_req_t   req_i,
    output valu_pkg::minmax_res_t minmax_o
);

    valu_pkg::vec_t a;
    valu_pkg::vec_t b;

    // a > b per element, unsigned and signed
    logic [valu_pkg::VLENB-1:0]     gtu_8b;
    logic [valu_pkg::VLENB-1:0]     gts_8b;
    logic [valu_pkg::VLENB/2-1:0]   gtu_16b;
    logic [valu_pkg::VLENB/2-1:0]   gts_16b;
    logic [valu_pkg::VLENB/4-1:0]   gtu_32b;
    logic [valu_pkg::VLENB/4-1:0]   gts_32b;

    assign a = req_i.first_operand;
    assign b = req_i.second_operand;

    ////////////////////////////////////////
    // Compare flags
    ////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < valu_pkg::VLENB; i++) begin
            gtu_8b[i] = a[8*i +: 8] > b[8*i +: 8];
            gts_8b[i] = $signed(a[8*i +: 8]) > $signed(b[8*i +: 8]);
        end
        for (int i = 0; i < valu_pkg::VLENB/2; i++) begin
            gtu_16b[i] = a[16*i +: 16] > b[16*i +: 16];
            gts_16b[i] = $signed(a[16*i +: 16]) > $signed(b[16*i +: 16]);
        end
        for (int i = 0; i < valu_pkg::VLENB/4; i++) begin
            gtu_32b[i] = a[32*i +: 32] > b[32*i +: 32];
            gts_32b[i] = $signed(a[32*i +: 32]) > $signed(b[32*i +: 32]);
        end
    end

    ////////////////////////////////////////
    // Element select
    ////////////////////////////////////////

    // Strict greater-than picks the element; ties keep the default side
    always_comb begin
        minmax_o = '0;
        case (req_i.sew)
            valu_pkg::EW8: begin
                for (int i = 0; i < valu_pkg::VLENB; i++) begin
                    minmax_o.minu[8*i +: 8] = gtu_8b[i] ? b[8*i +: 8] : a[8*i +: 8];
                    minmax_o.min[8*i +: 8]  = gts_8b[i] ? b[8*i +: 8] : a[8*i +: 8];
                    minmax_o.maxu[8*i +: 8] = gtu_8b[i] ? a[8*i +: 8] : b[8*i +: 8];
                    minmax_o.max[8*i +: 8]  = gts_8b[i] ? a[8*i +: 8] : b[8*i +: 8];
                end
            end
            valu_pkg::EW16: begin
                for (int i = 0; i < valu_pkg::VLENB/2; i++) begin
                    minmax_o.minu[16*i +: 16] = gtu_16b[i] ? b[16*i +: 16] : a[16*i +: 16];
                    minmax_o.min[16*i +: 16]  = gts_16b[i] ? b[16*i +: 16] : a[16*i +: 16];
                    minmax_o.maxu[16*i +: 16] = gtu_16b[i] ? a[16*i +: 16] : b[16*i +: 16];
                    minmax_o.max[16*i +: 16]  = gts_16b[i] ? a[16*i +: 16] : b[16*i +: 16];
                end
            end
            default: begin
                for (int i = 0; i < valu_pkg::VLENB/4; i++) begin
                    minmax_o.minu[32*i +: 32] = gtu_32b[i] ? b[32*i +: 32] : a[32*i +: 32];
                    minmax_o.min[32*i +: 32]  = gts_32b[i] ? b[32*i +: 32] : a[32*i +: 32];
                    minmax_o.maxu[32*i +: 32] = gtu_32b[i] ? a[32*i +: 32] : b[32*i +: 32];
                    minmax_o.max[32*i +: 32]  = gts_32b[i] ? a[32*i +: 32] : b[32*i +: 32];
                end
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/valu_pkg.sv */
`default_nettype none

package valu_pkg;

    ////////////////////////////////////////
    // Vector geometry
    ////////////////////////////////////////

    localparam int VLEN  = 64;
    localparam int VLENB = VLEN / 8;

    typedef logic [VLEN-1:0] vec_t;

    ////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////

    // Fourth code is decoded as 32-bit elements
    typedef enum logic [1:0] {
        EW8  = 2'b00,
        EW16 = 2'b01,
        EW32 = 2'b10
    } vew_e;

    // Codes 13 to 15 are free and execute as vadd
    typedef enum logic [3:0] {
        vadd  = 4'd0,
        vsub  = 4'd1,
        vrsub = 4'd2,
        vand  = 4'd3,
        vor   = 4'd4,
        vxor  = 4'd5,
        vsll  = 4'd6,
        vsrl  = 4'd7,
        vsra  = 4'd8,
        vmin  = 4'd9,
        vminu = 4'd10,
        vmax  = 4'd11,
        vmaxu = 4'd12
    } valu_op_e;

    ////////////////////////////////////////
    // Request and unit results
    ////////////////////////////////////////

    typedef struct packed {
        valu_op_e op;
        vew_e     sew;
        vec_t     first_operand;
        vec_t     second_operand;
    } valu_req_t;

    typedef struct packed {
        vec_t sll;
        vec_t srl;
        vec_t sra;
    } shift_res_t;

    typedef struct packed {
        vec_t min;
        vec_t minu;
        vec_t max;
        vec_t maxu;
    } minmax_res_t;

endpackage

`default_nettype wire

/* src/valu_result_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module valu_result_reg (
    input  logic                   clk,
    input  logic                   reset_n,
    input  valu_pkg::valu_req_t    req_i,
    input  valu_pkg::vec_t         sum_i,
    input  valu_pkg::shift_res_t   shift_i,
    input  valu_pkg::minmax_res_t  minmax_i,
    output valu_pkg::vec_t         result_o
);

    valu_pkg::vec_t result_and;
    valu_pkg::vec_t result_or;
    valu_pkg::vec_t result_xor;
    valu_pkg::vec_t result_next;

    ////////////////////////////////////////
    // Bitwise logic
    ////////////////////////////////////////

    // Element width plays no part here
    assign result_and = req_i.first_operand & req_i.second_operand;
    assign result_or  = req_i.first_operand | req_i.second_operand;
    assign result_xor = req_i.first_operand ^ req_i.second_operand;

    ////////////////////////////////////////
    // Result select and register
    ////////////////////////////////////////

    // Add, subtract, reverse subtract and free codes all take the adder
    always_comb begin
        case (req_i.op)
            valu_pkg::vand:  result_next = result_and;
            valu_pkg::vor:   result_next = result_or;
            valu_pkg::vxor:  result_next = result_xor;
            valu_pkg::vsll:  result_next = shift_i.sll;
            valu_pkg::vsrl:  result_next = shift_i.srl;
            valu_pkg::vsra:  result_next = shift_i.sra;
            valu_pkg::vmin:  result_next = minmax_i.min;
            valu_pkg::vminu: result_next = minmax_i.minu;
            valu_pkg::vmax:  result_next = minmax_i.max;
            valu_pkg::vmaxu: result_next = minmax_i.maxu;
            default:         result_next = sum_i;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            result_o <= '0;
        end else begin
            result_o <= result_next;
        end
    end

endmodule

`default_nettype wire

/* src/valu_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

module valu_shifter (
    input  valu_pkg::valu_req_t  req_i,
    output valu_pkg::shift_res_t shift_o
);

    valu_pkg::vec_t a;
    valu_pkg::vec_t b;

    assign a = req_i.first_operand;
    assign b = req_i.second_operand;

    ////////////////////////////////////////
    // Element shifters
    ////////////////////////////////////////

    // Amount is the low log2(W) bits of the matching element of b
    always_comb begin
        shift_o = '0;
        case (req_i.sew)
            valu_pkg::EW8: begin
                for (int i = 0; i < valu_pkg::VLENB; i++) begin
                    shift_o.sll[8*i +: 8] = a[8*i +: 8] << b[8*i +: 3];
                    shift_o.srl[8*i +: 8] = a[8*i +: 8] >> b[8*i +: 3];
                    shift_o.sra[8*i +: 8] = $signed(a[8*i +: 8]) >>> b[8*i +: 3];
                end
            end
            valu_pkg::EW16: begin
                for (int i = 0; i < valu_pkg::VLENB/2; i++) begin
                    shift_o.sll[16*i +: 16] = a[16*i +: 16] << b[16*i +: 4];
                    shift_o.srl[16*i +: 16] = a[16*i +: 16] >> b[16*i +: 4];
                    shift_o.sra[16*i +: 16] = $signed(a[16*i +: 16]) >>> b[16*i +: 4];
                end
            end
            default: begin
                // 32-bit elements, also taken for the spare width code
                for (int i = 0; i < valu_pkg::VLENB/4; i++) begin
                    shift_o.sll[32*i +: 32] = a[32*i +: 32] << b[32*i +: 5];
                    shift_o.srl[32*i +: 32] = a[32*i +: 32] >> b[32*i +: 5];
                    shift_o.sra[32*i +: 32] = $signed(a[32*i +: 32]) >>> b[32*i +: 5];
                end
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/valu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module valu_top (
    input  logic                clk,
    input  logic                reset_n,
    input  valu_pkg::valu_req_t req_i,
    output valu_pkg::vec_t      result_o
);

    valu_pkg::vec_t        sum;
    valu_pkg::shift_res_t  shift_res;
    valu_pkg::minmax_res_t minmax_res;

    ////////////////////////////////////////
    // Combinational units
    ////////////////////////////////////////

    valu_adder i_valu_adder (
        .req_i (req_i),
        .sum_o (sum)
    );

    valu_shifter i_valu_shifter (
        .req_i   (req_i),
        .shift_o (shift_res)
    );

    valu_minmax i_valu_minmax (
        .req_i    (req_i),
        .minmax_o (minmax_res)
    );

    ////////////////////////////////////////
    // Output stage
    ////////////////////////////////////////

    // Single register stage, one cycle from request to result
    valu_result_reg i_valu_result_reg (
        .clk      (clk),
        .reset_n  (reset_n),
        .req_i    (req_i),
        .sum_i    (sum),
        .shift_i  (shift_res),
        .minmax_i (minmax_res),
        .result_o (result_o)
    );

endmodule

`default_nettype wire

/* tb/valu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module valu_tb;

    logic                clk;
    logic                reset_n;
    valu_pkg::valu_req_t req;
    valu_pkg::vec_t      result_o;

    // Request as it stood before the last rising edge
    valu_pkg::valu_req_t held_req;
    logic                held_reset_n;
    logic                held_valid = 1'b0;

    logic [31:0] rng_state = 32'h1b87_a7a8;
    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;

    valu_top i_valu_top (
        .clk      (clk),
        .reset_n  (reset_n),
        .req_i    (req),
        .result_o (result_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////
    // Random numbers and reference model
    ////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_random(output logic [31:0] value);
        rng_state = xorshift32(rng_state);
        value = rng_state;
    endtask

    task automatic random_vector(output valu_pkg::vec_t value);
        logic [31:0] hi;
        logic [31:0] lo;
        next_random(hi);
        next_random(lo);
        value = {hi, lo};
    endtask

    // Element rules applied one element at a time
    function automatic valu_pkg::vec_t expected_result(input valu_pkg::valu_req_t r);
        valu_pkg::vec_t  res;
        int              w;
        longint unsigned mask;
        longint unsigned sign;
        longint unsigned amt_mask;
        longint unsigned ea;
        longint unsigned eb;
        longint unsigned sh;
        longint unsigned er;
        longint          sa;
        longint          sb;
        res = '0;
        case (r.sew)
            valu_pkg::EW8: begin
                w = 8;
                mask = 64'hff;
                sign = 64'h80;
                amt_mask = 64'd7;
            end
            valu_pkg::EW16: begin
                w = 16;
                mask = 64'hffff;
                sign = 64'h8000;
                amt_mask = 64'd15;
            end
            default: begin
                w = 32;
                mask = 64'hffff_ffff;
                sign = 64'h8000_0000;
                amt_mask = 64'd31;
            end
        endcase
        case (r.op)
            valu_pkg::vand: res = r.first_operand & r.second_operand;
            valu_pkg::vor:  res = r.first_operand | r.second_operand;
            valu_pkg::vxor: res = r.first_operand ^ r.second_operand;
            default: begin
                for (int i = 0; i < valu_pkg::VLEN / w; i++) begin
                    ea = (r.first_operand >> (i * w)) & mask;
                    eb = (r.second_operand >> (i * w)) & mask;
                    sh = eb & amt_mask;
                    // Sign extend both elements to 64 bits
                    sa = ((ea & sign) != 64'd0) ? $signed(ea | ~mask) : $signed(ea);
                    sb = ((eb & sign) != 64'd0) ? $signed(eb | ~mask) : $signed(eb);
                    case (r.op)
                        valu_pkg::vsub:  er = ea - eb;
                        valu_pkg::vrsub: er = eb - ea;
                        valu_pkg::vsll:  er = ea << sh;
                        valu_pkg::vsrl:  er = ea >> sh;
                        valu_pkg::vsra:  er = sa >>> sh;
                        valu_pkg::vmin:  er = (sa < sb) ? ea : eb;
                        valu_pkg::vminu: er = (ea < eb) ? ea : eb;
                        valu_pkg::vmax:  er = (sa > sb) ? ea : eb;
                        valu_pkg::vmaxu: er = (ea > eb) ? ea : eb;
                        default:         er = ea + eb;
                    endcase
                    res = res | ((er & mask) << (i * w));
                end
            end
        endcase
        return res;
    endfunction

    ////////////////////////////////////////
    // Checker
    ////////////////////////////////////////

    always @(negedge clk) begin
        held_req     = req;
        held_reset_n = reset_n;
        held_valid   = 1'b1;
    end

    // Compare just after the edge, once the register has settled
    always @(posedge clk) begin
        valu_pkg::vec_t expected;
        #1;
        if (held_valid) begin
            if (held_reset_n) begin
                expected = expected_result(held_req);
            end else begin
                expected = '0;
            end
            check_count++;
            if (result_o !== expected) begin
                error_count++;
                $display("CHECK FAILED at %0t: op=%0d sew=%0d a=%h b=%h expected=%h actual=%h",
                         $time, held_req.op, held_req.sew, held_req.first_operand,
                         held_req.second_operand, expected, result_o);
            end
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic send_request(input valu_pkg::valu_op_e op, input valu_pkg::vew_e sew,
                                input valu_pkg::vec_t a, input valu_pkg::vec_t b);
        @(posedge clk);
        #10;
        req.op             = op;
        req.sew            = sew;
        req.first_operand  = a;
        req.second_operand = b;
    endtask

    task automatic send_all_widths(input valu_pkg::valu_op_e op,
                                   input valu_pkg::vec_t a, input valu_pkg::vec_t b);
        for (int w = 0; w < 3; w++) begin
            send_request(op, valu_pkg::vew_e'(w), a, b);
        end
    endtask

    task automatic add_sub_case(input valu_pkg::vec_t a, input valu_pkg::vec_t b);
        send_all_widths(valu_pkg::vadd, a, b);
        send_all_widths(valu_pkg::vsub, a, b);
        send_all_widths(valu_pkg::vrsub, a, b);
    endtask

    task automatic shift_case(input valu_pkg::vec_t a, input valu_pkg::vec_t b);
        send_all_widths(valu_pkg::vsll, a, b);
        send_all_widths(valu_pkg::vsrl, a, b);
        send_all_widths(valu_pkg::vsra, a, b);
    endtask

    task automatic minmax_case(input valu_pkg::vec_t a, input valu_pkg::vec_t b);
        send_all_widths(valu_pkg::vmin, a, b);
        send_all_widths(valu_pkg::vminu, a, b);
        send_all_widths(valu_pkg::vmax, a, b);
        send_all_widths(valu_pkg::vmaxu, a, b);
    endtask

    initial begin
        valu_pkg::vec_t x;
        valu_pkg::vec_t y;
        logic [31:0]    word;
        reset_n = 1'b0;
        req     = '0;
        // A live add request during reset, which must not reach the output
        req.first_operand  = 64'h0123_4567_89ab_cdef;
        req.second_operand = 64'h1111_1111_1111_1111;
        repeat (5) @(posedge clk);
        #10;
        reset_n = 1'b1;
        req     = '0;

        // Idle request registers as zero plus zero
        @(posedge clk);
        #1;
        if (result_o !== '0) begin
            error_count++;
            $display("CHECK FAILED at %0t: result after reset release is %h, expected zero",
                     $time, result_o);
        end

        // Carries and borrows that would cross element boundaries
        add_sub_case(64'hffff_ffff_ffff_ffff, 64'h0000_0000_0000_0001);
        add_sub_case(64'hffff_ffff_ffff_ffff, 64'h0101_0101_0101_0101);
        add_sub_case(64'h00ff_7fff_ffff_ffff, 64'h0001_0001_0000_0001);
        add_sub_case(64'h0000_0000_0000_0000, 64'h0000_0001_0000_0001);

        repeat (4) begin
            random_vector(x);
            random_vector(y);
            send_all_widths(valu_pkg::vand, x, y);
            send_all_widths(valu_pkg::vor, x, y);
            send_all_widths(valu_pkg::vxor, x, y);
        end

        // Amounts above the element width, then negative elements for vsra
        shift_case(64'h8123_4567_89ab_cdef, 64'h3f1f_0f09_2827_ff11);
        shift_case(64'hf0f0_8000_ffff_8001, 64'h0107_0f1f_0204_0803);
        random_vector(x);
        random_vector(y);
        shift_case(x, y);

        // Elements differing in the sign bit, so the two orderings disagree
        minmax_case(64'h8512_8512_8512_8512, 64'h0592_0592_0592_0592);
        minmax_case(64'h0592_0592_0592_0592, 64'h8512_8512_8512_8512);
        random_vector(x);
        minmax_case(x, x);
        random_vector(y);
        minmax_case(x, y);

        // Back-to-back random stream, free opcodes included
        repeat (3000) begin
            next_random(word);
            random_vector(x);
            random_vector(y);
            send_request(valu_pkg::valu_op_e'(word[3:0]), valu_pkg::vew_e'(word[5:4]), x, y);
        end

        @(posedge clk);
        #10;
        req = '0;
        repeat (2) @(posedge clk);
        #5;
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    ////////////////////////////////////////
    // Timeout
    ////////////////////////////////////////

    // Tests need roughly 3200 cycles
    initial begin
        while (cycle_count < 4000) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within 4000 clock cycles");
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire
